// File: design/plat_pkg.sv
package plat_pkg;

	// *******************************************************************
	// Sizes and basic types
	// *******************************************************************
	localparam int NUM_CORE = 2;
	localparam int MAX_CORE = 4;

	typedef logic [31:0] word_t;
	typedef logic [11:0] addr_t;
	typedef logic [3:0] boot_mode_t;
	typedef logic [$clog2(MAX_CORE)-1:0] core_idx_t;
	// Holds 0 up to 2*NUM_CORE
	typedef logic [$clog2(2*NUM_CORE+1)-1:0] fin_cnt_t;

	typedef enum logic [1:0] {
		BOOT_RESET     = 2'd0,
		BOOT_APP_LOAD  = 2'd1,
		BOOT_ALL_READY = 2'd2
	} boot_status_e;

	// *******************************************************************
	// Register map
	// *******************************************************************
	localparam addr_t REG_BOOT_MODE       = 12'h000;
	localparam addr_t REG_BOOT_STATUS     = 12'h004;
	localparam addr_t REG_BOOT_CMD        = 12'h008;
	localparam addr_t REG_JTAG_SEL        = 12'h00C;
	localparam addr_t REG_CORE_FINISH     = 12'h010;
	localparam addr_t REG_FINISH_CNT      = 12'h014;
	localparam addr_t REG_EXIT_REQ        = 12'h018;
	localparam addr_t REG_IMP_TYPE        = 12'h01C;
	localparam addr_t REG_FLASH_BASE      = 12'h020;
	localparam addr_t REG_SCRATCH         = 12'h024;
	localparam addr_t REG_RESET_PC_BASE   = 12'h040;
	localparam addr_t REG_RESET_INST_BASE = 12'h060;

	// Command codes and read-only values
	localparam word_t BOOT_CMD_LOAD  = 32'd1;
	localparam word_t BOOT_CMD_READY = 32'd2;
	localparam word_t IMP_TYPE_RTL   = 32'h0000_0001;
	localparam word_t FLASH_BASE     = 32'h2000_0000;
	localparam word_t INVALID_WORD   = 32'hFFFF_FFFF;

	// *******************************************************************
	// Bus structures
	// *******************************************************************
	typedef struct packed {
		logic  sel;
		logic  enable;
		logic  write;
		addr_t addr;
		word_t wdata;
	} apb_req_t;

	typedef struct packed {
		logic  ready;
		logic  slverr;
		word_t rdata;
	} apb_rsp_t;

	// Internal single-cycle access toward the register file
	typedef struct packed {
		logic  valid;
		logic  write;
		addr_t addr;
		word_t wdata;
	} reg_acc_t;

	typedef struct packed {
		logic  done;
		logic  err;
		word_t rdata;
	} reg_rsp_t;

endpackage

// File: design/plat_sync_bank.sv
module plat_sync_bank
(
	input  logic rvx_port_08,
	input  logic rvx_port_14,

	input  plat_pkg::boot_mode_t i_boot_mode,
	input  logic i_jtag_sel,
	input  plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] i_reset_pc,
	input  plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] i_reset_inst,

	output plat_pkg::boot_mode_t o_boot_mode,
	output logic o_jtag_sel,
	output plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] o_reset_pc,
	output plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] o_reset_inst
);

	// All asynchronous pins gathered into one vector
	typedef struct packed {
		plat_pkg::boot_mode_t boot_mode;
		logic jtag_sel;
		plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] reset_pc;
		plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] reset_inst;
	} pin_t;

	pin_t pin_async;
	pin_t pin_meta;
	pin_t pin_sync;

	assign pin_async = '{boot_mode: i_boot_mode, jtag_sel: i_jtag_sel,
		reset_pc: i_reset_pc, reset_inst: i_reset_inst};

	// Two flop stages per bit
	always_ff @(posedge rvx_port_08, negedge rvx_port_14)
	begin
		if (!rvx_port_14)
		begin
			pin_meta <= '0;
			pin_sync <= '0;
		end
		else
		begin
			pin_meta <= pin_async;
			pin_sync <= pin_meta;
		end
	end

	assign o_boot_mode  = pin_sync.boot_mode;
	assign o_jtag_sel   = pin_sync.jtag_sel;
	assign o_reset_pc   = pin_sync.reset_pc;
	assign o_reset_inst = pin_sync.reset_inst;

endmodule

// File: design/plat_bus_arbiter.sv
module plat_bus_arbiter
(
	input  logic rvx_port_08,
	input  logic rvx_port_14,

	input  plat_pkg::apb_req_t i_core_req,
	input  plat_pkg::apb_req_t i_dbg_req,
	input  plat_pkg::reg_rsp_t i_rsp,

	output plat_pkg::apb_rsp_t o_core_rsp,
	output plat_pkg::apb_rsp_t o_dbg_rsp,
	output plat_pkg::reg_acc_t o_acc
);

	typedef enum logic [1:0] {
		IDLE,
		GRANT_CORE,
		GRANT_DBG
	} grant_e;

	grant_e state;
	grant_e state_next;
	logic core_access;
	logic dbg_access;
	logic acc_issued;
	plat_pkg::apb_req_t req_sel;

	// A port competes only in its access phase
	assign core_access = i_core_req.sel & i_core_req.enable;
	assign dbg_access  = i_dbg_req.sel & i_dbg_req.enable;

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (dbg_access)
					state_next = GRANT_DBG;
				else if (core_access)
					state_next = GRANT_CORE;
			GRANT_CORE, GRANT_DBG:
				if (i_rsp.done)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge rvx_port_08, negedge rvx_port_14)
	begin
		if (!rvx_port_14)
			state <= IDLE;
		else
			state <= state_next;
	end

	// Grant is held until done, so issue only once per grant
	always_ff @(posedge rvx_port_08, negedge rvx_port_14)
	begin
		if (!rvx_port_14)
			acc_issued <= 1'b0;
		else if (o_acc.valid)
			acc_issued <= 1'b1;
		else if (i_rsp.done)
			acc_issued <= 1'b0;
	end

	assign req_sel = (state == GRANT_DBG) ? i_dbg_req : i_core_req;

	assign o_acc.valid = (state != IDLE) & ~acc_issued;
	assign o_acc.write = req_sel.write;
	assign o_acc.addr  = req_sel.addr;
	assign o_acc.wdata = req_sel.wdata;

	// Response goes to the granted port only
	assign o_core_rsp.ready  = i_rsp.done & (state == GRANT_CORE);
	assign o_core_rsp.slverr = o_core_rsp.ready & i_rsp.err;
	assign o_core_rsp.rdata  = i_rsp.rdata;

	assign o_dbg_rsp.ready  = i_rsp.done & (state == GRANT_DBG);
	assign o_dbg_rsp.slverr = o_dbg_rsp.ready & i_rsp.err;
	assign o_dbg_rsp.rdata  = i_rsp.rdata;

endmodule

// File: design/plat_vector_table.sv
module plat_vector_table
(
	input  plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] i_reset_pc,
	input  plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] i_reset_inst,
	input  plat_pkg::core_idx_t i_idx,
	input  logic i_sel_inst,

	output plat_pkg::word_t o_word
);

	plat_pkg::word_t pc_slot [plat_pkg::MAX_CORE];
	plat_pkg::word_t inst_slot [plat_pkg::MAX_CORE];

	// Slots without a core read back as all ones
	for (genvar g = 0; g < plat_pkg::MAX_CORE; g++)
	begin : g_slot
		if (g < plat_pkg::NUM_CORE)
		begin : g_used
			assign pc_slot[g]   = i_reset_pc[g];
			assign inst_slot[g] = i_reset_inst[g];
		end
		else
		begin : g_pad
			assign pc_slot[g]   = plat_pkg::INVALID_WORD;
			assign inst_slot[g] = plat_pkg::INVALID_WORD;
		end
	end

	assign o_word = i_sel_inst ? inst_slot[i_idx] : pc_slot[i_idx];

endmodule

// File: design/plat_finish_counter.sv
module plat_finish_counter
(
	input  logic rvx_port_08,
	input  logic rvx_port_14,

	input  logic i_finish,

	output plat_pkg::fin_cnt_t o_count,
	output logic o_all_done
);

	plat_pkg::fin_cnt_t count;

	// Holds at full scale instead of wrapping
	always_ff @(posedge rvx_port_08, negedge rvx_port_14)
	begin
		if (!rvx_port_14)
			count <= '0;
		else if (i_finish && (count != '1))
			count <= count + 1'b1;
	end

	assign o_count = count;

	// Every core reports twice
	assign o_all_done = (count == plat_pkg::fin_cnt_t'(2 * plat_pkg::NUM_CORE));

endmodule

// File: design/plat_ctrl.sv
module plat_ctrl
(
	input  logic rvx_port_08,
	input  logic rvx_port_14,

	input  plat_pkg::reg_acc_t i_acc,
	input  plat_pkg::boot_mode_t i_boot_mode,
	input  logic i_jtag_sel,
	input  plat_pkg::word_t i_vec_word,
	input  plat_pkg::fin_cnt_t i_fin_count,

	output plat_pkg::reg_rsp_t o_rsp,
	output plat_pkg::core_idx_t o_vec_idx,
	output logic o_vec_sel_inst,
	output logic o_finish,
	output logic o_exit_req
);

	plat_pkg::boot_status_e boot_status;
	plat_pkg::word_t scratch;
	plat_pkg::word_t rd_data;
	plat_pkg::word_t rsp_rdata;
	logic rsp_done;
	logic rsp_err;
	logic acc_err;
	logic vec_hit;
	logic wr_en;
	logic exit_flag;

	// *******************************************************************
	// Decode and read mux
	// *******************************************************************
	assign o_vec_sel_inst = (i_acc.addr[11:4] == plat_pkg::REG_RESET_INST_BASE[11:4]);
	assign o_vec_idx = i_acc.addr[3:2];
	assign vec_hit = ((i_acc.addr[11:4] == plat_pkg::REG_RESET_PC_BASE[11:4]) ||
		o_vec_sel_inst) && (i_acc.addr[1:0] == 2'b00);

	always_comb
	begin
		rd_data = '0;
		acc_err = i_acc.write;
		case (i_acc.addr)
			plat_pkg::REG_BOOT_MODE:   rd_data = plat_pkg::word_t'(i_boot_mode);
			plat_pkg::REG_BOOT_STATUS: rd_data = plat_pkg::word_t'(boot_status);
			plat_pkg::REG_JTAG_SEL:    rd_data = plat_pkg::word_t'(i_jtag_sel);
			plat_pkg::REG_FINISH_CNT:  rd_data = plat_pkg::word_t'(i_fin_count);
			plat_pkg::REG_IMP_TYPE:    rd_data = plat_pkg::IMP_TYPE_RTL;
			plat_pkg::REG_FLASH_BASE:  rd_data = plat_pkg::FLASH_BASE;
			// Command registers take writes only
			plat_pkg::REG_BOOT_CMD, plat_pkg::REG_CORE_FINISH:
				acc_err = ~i_acc.write;
			plat_pkg::REG_EXIT_REQ:
			begin
				rd_data = plat_pkg::word_t'(exit_flag);
				acc_err = 1'b0;
			end
			plat_pkg::REG_SCRATCH:
			begin
				rd_data = scratch;
				acc_err = 1'b0;
			end
			default:
				if (vec_hit)
					rd_data = i_vec_word;
				else
					acc_err = 1'b1;
		endcase
	end

	assign wr_en = i_acc.valid & i_acc.write & ~acc_err;

	// *******************************************************************
	// Response, one cycle after the access
	// *******************************************************************
	always_ff @(posedge rvx_port_08, negedge rvx_port_14)
	begin
		if (!rvx_port_14)
			rsp_done <= 1'b0;
		else
			rsp_done <= i_acc.valid;
	end

	always_ff @(posedge rvx_port_08)
	begin
		if (i_acc.valid)
		begin
			rsp_err   <= acc_err;
			rsp_rdata <= (i_acc.write || acc_err) ? '0 : rd_data;
		end
	end

	assign o_rsp.done  = rsp_done;
	assign o_rsp.err   = rsp_err;
	assign o_rsp.rdata = rsp_rdata;

	// *******************************************************************
	// Writable state
	// *******************************************************************
	always_ff @(posedge rvx_port_08, negedge rvx_port_14)
	begin
		if (!rvx_port_14)
		begin
			boot_status <= plat_pkg::BOOT_RESET;
			exit_flag   <= 1'b0;
			scratch     <= '0;
			o_finish    <= 1'b0;
		end
		else
		begin
			o_finish <= wr_en && (i_acc.addr == plat_pkg::REG_CORE_FINISH);
			if (wr_en && (i_acc.addr == plat_pkg::REG_SCRATCH))
				scratch <= i_acc.wdata;
			// Sticky until reset
			if (wr_en && (i_acc.addr == plat_pkg::REG_EXIT_REQ) && i_acc.wdata[0])
				exit_flag <= 1'b1;
			if (wr_en && (i_acc.addr == plat_pkg::REG_BOOT_CMD))
			begin
				// Unknown commands are dropped quietly
				if ((boot_status == plat_pkg::BOOT_RESET) &&
					(i_acc.wdata == plat_pkg::BOOT_CMD_LOAD))
					boot_status <= plat_pkg::BOOT_APP_LOAD;
				else if ((boot_status == plat_pkg::BOOT_APP_LOAD) &&
					(i_acc.wdata == plat_pkg::BOOT_CMD_READY))
					boot_status <= plat_pkg::BOOT_ALL_READY;
			end
		end
	end

	assign o_exit_req = exit_flag;

endmodule

// File: design/plat_top.sv
module plat_top
(
	input  logic rvx_port_08,
	input  logic rvx_port_14,

	input  plat_pkg::apb_req_t i_core_req,
	output plat_pkg::apb_rsp_t o_core_rsp,
	input  plat_pkg::apb_req_t i_dbg_req,
	output plat_pkg::apb_rsp_t o_dbg_rsp,

	input  plat_pkg::boot_mode_t i_boot_mode,
	input  logic i_jtag_sel,
	input  plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] i_reset_pc,
	input  plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] i_reset_inst,

	output logic o_all_done,
	output logic o_exit_req
);

	plat_pkg::reg_acc_t acc;
	plat_pkg::reg_rsp_t rsp;
	plat_pkg::boot_mode_t boot_mode_sync;
	logic jtag_sel_sync;
	plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] reset_pc_sync;
	plat_pkg::word_t [plat_pkg::NUM_CORE-1:0] reset_inst_sync;
	plat_pkg::core_idx_t vec_idx;
	logic vec_sel_inst;
	plat_pkg::word_t vec_word;
	logic finish;
	plat_pkg::fin_cnt_t fin_count;

	plat_sync_bank u_sync (
		.rvx_port_08(rvx_port_08), .rvx_port_14(rvx_port_14),
		.i_boot_mode(i_boot_mode), .i_jtag_sel(i_jtag_sel),
		.i_reset_pc(i_reset_pc), .i_reset_inst(i_reset_inst),
		.o_boot_mode(boot_mode_sync), .o_jtag_sel(jtag_sel_sync),
		.o_reset_pc(reset_pc_sync), .o_reset_inst(reset_inst_sync)
	);

	plat_bus_arbiter u_arbiter (
		.rvx_port_08(rvx_port_08), .rvx_port_14(rvx_port_14),
		.i_core_req(i_core_req), .i_dbg_req(i_dbg_req), .i_rsp(rsp),
		.o_core_rsp(o_core_rsp), .o_dbg_rsp(o_dbg_rsp), .o_acc(acc)
	);

	plat_vector_table u_vec_table (
		.i_reset_pc(reset_pc_sync), .i_reset_inst(reset_inst_sync),
		.i_idx(vec_idx), .i_sel_inst(vec_sel_inst), .o_word(vec_word)
	);

	plat_finish_counter u_fin_cnt (
		.rvx_port_08(rvx_port_08), .rvx_port_14(rvx_port_14),
		.i_finish(finish), .o_count(fin_count), .o_all_done(o_all_done)
	);

	plat_ctrl u_ctrl (
		.rvx_port_08(rvx_port_08), .rvx_port_14(rvx_port_14),
		.i_acc(acc), .i_boot_mode(boot_mode_sync), .i_jtag_sel(jtag_sel_sync),
		.i_vec_word(vec_word), .i_fin_count(fin_count),
		.o_rsp(rsp), .o_vec_idx(vec_idx), .o_vec_sel_inst(vec_sel_inst),
		.o_finish(finish), .o_exit_req(o_exit_req)
	);

endmodule

// File: sim/plat_sva.sv
module plat_sva
(
	input logic rvx_port_08,
	input logic rvx_port_14,
	input plat_pkg::apb_req_t i_core_req,
	input plat_pkg::apb_req_t i_dbg_req,
	input plat_pkg::apb_rsp_t i_core_rsp,
	input plat_pkg::apb_rsp_t i_dbg_rsp,
	input logic [1:0] i_boot_status
);

	// Only the granted port sees ready
	a_one_ready: assert property (@(posedge rvx_port_08) disable iff (!rvx_port_14)
		!(i_core_rsp.ready && i_dbg_rsp.ready))
		else $error("ready high on both ports in the same cycle");

	// Master holds its request while the access phase waits
	a_core_hold: assert property (@(posedge rvx_port_08) disable iff (!rvx_port_14)
		(i_core_req.sel && i_core_req.enable && !i_core_rsp.ready) |=> $stable(i_core_req))
		else $error("core request changed before ready");

	a_dbg_hold: assert property (@(posedge rvx_port_08) disable iff (!rvx_port_14)
		(i_dbg_req.sel && i_dbg_req.enable && !i_dbg_rsp.ready) |=> $stable(i_dbg_req))
		else $error("debug request changed before ready");

	a_boot_fwd: assert property (@(posedge rvx_port_08) disable iff (!rvx_port_14)
		i_boot_status >= $past(i_boot_status))
		else $error("boot status moved backwards");

endmodule

bind plat_top plat_sva u_sva (
	.rvx_port_08(rvx_port_08), .rvx_port_14(rvx_port_14),
	.i_core_req(i_core_req), .i_dbg_req(i_dbg_req),
	.i_core_rsp(o_core_rsp), .i_dbg_rsp(o_dbg_rsp),
	.i_boot_status(u_ctrl.boot_status)
);

// File: sim/plat_tb.sv
module plat_tb;

	localparam logic CORE = 1'b0;
	localparam logic DBG  = 1'b1;
	localparam logic RD   = 1'b0;
	localparam logic WR   = 1'b1;

	// Fixed pin values seen by the DUT
	localparam logic [3:0] PIN_BOOT_MODE = 4'h5;
	localparam logic [31:0] PIN_PC0   = 32'h0000_1000;
	localparam logic [31:0] PIN_PC1   = 32'h0000_2000;
	localparam logic [31:0] PIN_INST0 = 32'h0000_0013;
	localparam logic [31:0] PIN_INST1 = 32'h0000_006F;

	// One bus access plus the outputs expected once it is done
	typedef struct packed {
		logic port;
		logic write;
		plat_pkg::addr_t addr;
		plat_pkg::word_t wdata;
		plat_pkg::word_t exp_rdata;
		logic exp_err;
		logic pair;
		logic exp_done;
		logic exp_exit;
	} entry_t;

	logic rvx_port_08;
	logic rvx_port_14;
	plat_pkg::apb_req_t core_req;
	plat_pkg::apb_req_t dbg_req;
	plat_pkg::apb_rsp_t core_rsp;
	plat_pkg::apb_rsp_t dbg_rsp;
	logic all_done;
	logic exit_req;
	entry_t table_q[$];
	logic table_ready;
	logic model_done;
	logic model_exit;
	logic [31:0] rnd_state;
	int idx;

	plat_top DUT (
		.rvx_port_08(rvx_port_08), .rvx_port_14(rvx_port_14),
		.i_core_req(core_req), .o_core_rsp(core_rsp),
		.i_dbg_req(dbg_req), .o_dbg_rsp(dbg_rsp),
		.i_boot_mode(PIN_BOOT_MODE), .i_jtag_sel(1'b1),
		.i_reset_pc({PIN_PC1, PIN_PC0}), .i_reset_inst({PIN_INST1, PIN_INST0}),
		.o_all_done(all_done), .o_exit_req(exit_req)
	);

	always #20 rvx_port_08 = ~rvx_port_08;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s got 0x%h expected 0x%h", name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic push_entry(input logic port, input logic write, input plat_pkg::addr_t addr,
		input plat_pkg::word_t wdata, input plat_pkg::word_t exp_rdata, input logic exp_err,
		input logic pair);
		entry_t e;
		e = '{port: port, write: write, addr: addr, wdata: wdata, exp_rdata: exp_rdata,
			exp_err: exp_err, pair: pair, exp_done: model_done, exp_exit: model_exit};
		table_q.push_back(e);
	endtask

	// *******************************************************************
	// APB setup and access phase on either port
	// *******************************************************************
	task automatic bus_xfer(input logic port, input logic write, input plat_pkg::addr_t addr,
		input plat_pkg::word_t wdata, output plat_pkg::word_t rdata, output logic err);
		plat_pkg::apb_req_t req;
		plat_pkg::apb_rsp_t rsp;
		int wait_cycles;
		req = '{sel: 1'b1, enable: 1'b0, write: write, addr: addr, wdata: wdata};
		wait_cycles = 0;
		@(posedge rvx_port_08);
		if (port == DBG)
			dbg_req <= req;
		else
			core_req <= req;
		req.enable = 1'b1;
		@(posedge rvx_port_08);
		if (port == DBG)
			dbg_req <= req;
		else
			core_req <= req;
		@(negedge rvx_port_08);
		rsp = (port == DBG) ? dbg_rsp : core_rsp;
		while (!rsp.ready)
		begin
			wait_cycles++;
			if (wait_cycles > 12)
			begin
				$display("Access to offset 0x%h never got ready on port %0d", addr, port);
				$display("** FAIL **");
				$fatal(1);
			end
			@(negedge rvx_port_08);
			rsp = (port == DBG) ? dbg_rsp : core_rsp;
		end
		rdata = rsp.rdata;
		err = rsp.slverr;
		// Back to idle at the edge that closes the ready cycle
		req.sel = 1'b0;
		req.enable = 1'b0;
		@(posedge rvx_port_08);
		if (port == DBG)
			dbg_req <= req;
		else
			core_req <= req;
	endtask

	task automatic run_entry(input int n);
		entry_t e;
		plat_pkg::word_t rdata;
		logic err;
		e = table_q[n];
		bus_xfer(e.port, e.write, e.addr, e.wdata, rdata, err);
		check_value($sformatf("slverr@%h", e.addr), 32'(err), 32'(e.exp_err));
		if (!e.write && !e.exp_err)
			check_value($sformatf("rdata@%h", e.addr), rdata, e.exp_rdata);
		@(negedge rvx_port_08);
		check_value("o_all_done", 32'(all_done), 32'(e.exp_done));
		check_value("o_exit_req", 32'(exit_req), 32'(e.exp_exit));
	endtask

	// *******************************************************************
	// Stimulus table and main sequence
	// *******************************************************************
	initial
	begin
		rvx_port_08 = 1'b0;
		rvx_port_14 = 1'b0;
		core_req = '0;
		dbg_req = '0;
		table_ready = 1'b0;
		model_done = 1'b0;
		model_exit = 1'b0;
		rnd_state = 32'h137c_da08;

		// Pins, vector slots and constants
		push_entry(DBG, RD, plat_pkg::REG_BOOT_MODE, '0, 32'(PIN_BOOT_MODE), 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_JTAG_SEL, '0, 32'h1, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_RESET_PC_BASE, '0, PIN_PC0, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_RESET_PC_BASE + 12'h4, '0, PIN_PC1, 1'b0, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_RESET_INST_BASE, '0, PIN_INST0, 1'b0, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_RESET_INST_BASE + 12'h4, '0, PIN_INST1, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_RESET_PC_BASE + 12'h8, '0, 32'hFFFF_FFFF, 1'b0, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_RESET_INST_BASE + 12'hC, '0, 32'hFFFF_FFFF, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_IMP_TYPE, '0, 32'h0000_0001, 1'b0, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_FLASH_BASE, '0, 32'h2000_0000, 1'b0, 1'b0);

		// Boot status, READY before LOAD is ignored
		push_entry(CORE, RD, plat_pkg::REG_BOOT_STATUS, '0, 32'd0, 1'b0, 1'b0);
		push_entry(CORE, WR, plat_pkg::REG_BOOT_CMD, 32'd2, '0, 1'b0, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_BOOT_STATUS, '0, 32'd0, 1'b0, 1'b0);
		push_entry(DBG, WR, plat_pkg::REG_BOOT_CMD, 32'd1, '0, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_BOOT_STATUS, '0, 32'd1, 1'b0, 1'b0);
		push_entry(DBG, WR, plat_pkg::REG_BOOT_CMD, 32'd2, '0, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_BOOT_STATUS, '0, 32'd2, 1'b0, 1'b0);

		// Finish reports, two per core
		repeat (3)
			push_entry(CORE, WR, plat_pkg::REG_CORE_FINISH, 32'd1, '0, 1'b0, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_FINISH_CNT, '0, 32'd3, 1'b0, 1'b0);
		model_done = 1'b1;
		push_entry(DBG, WR, plat_pkg::REG_CORE_FINISH, 32'd1, '0, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_FINISH_CNT, '0, 32'd4, 1'b0, 1'b0);

		// Error responses
		push_entry(CORE, RD, 12'h030, '0, '0, 1'b1, 1'b0);
		push_entry(DBG, WR, plat_pkg::REG_BOOT_MODE, 32'h3, '0, 1'b1, 1'b0);
		push_entry(CORE, WR, plat_pkg::REG_FLASH_BASE, 32'h0, '0, 1'b1, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_BOOT_CMD, '0, '0, 1'b1, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_RESET_PC_BASE + 12'h2, '0, '0, 1'b1, 1'b0);

		// Scratch round trips across the two ports
		rnd_state = xorshift32(rnd_state);
		push_entry(CORE, WR, plat_pkg::REG_SCRATCH, rnd_state, '0, 1'b0, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_SCRATCH, '0, rnd_state, 1'b0, 1'b0);
		rnd_state = xorshift32(rnd_state);
		push_entry(DBG, WR, plat_pkg::REG_SCRATCH, rnd_state, '0, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_SCRATCH, '0, rnd_state, 1'b0, 1'b0);

		// Both ports at once, debug first
		push_entry(DBG, RD, plat_pkg::REG_BOOT_MODE, '0, 32'(PIN_BOOT_MODE), 1'b0, 1'b1);
		push_entry(CORE, RD, plat_pkg::REG_SCRATCH, '0, rnd_state, 1'b0, 1'b0);
		// Core sees the word that debug wrote in the same round
		rnd_state = xorshift32(rnd_state);
		push_entry(DBG, WR, plat_pkg::REG_SCRATCH, rnd_state, '0, 1'b0, 1'b1);
		push_entry(CORE, RD, plat_pkg::REG_SCRATCH, '0, rnd_state, 1'b0, 1'b0);
		push_entry(DBG, RD, plat_pkg::REG_SCRATCH, '0, rnd_state, 1'b0, 1'b0);

		// Exit request is sticky
		push_entry(CORE, RD, plat_pkg::REG_EXIT_REQ, '0, 32'd0, 1'b0, 1'b0);
		model_exit = 1'b1;
		push_entry(CORE, WR, plat_pkg::REG_EXIT_REQ, 32'd1, '0, 1'b0, 1'b0);
		push_entry(DBG, WR, plat_pkg::REG_EXIT_REQ, 32'd0, '0, 1'b0, 1'b0);
		push_entry(CORE, RD, plat_pkg::REG_EXIT_REQ, '0, 32'd1, 1'b0, 1'b0);
		table_ready = 1'b1;

		repeat (2) @(posedge rvx_port_08);
		rvx_port_14 <= 1'b1;
		@(negedge rvx_port_08);
		check_value("core ready", 32'(core_rsp.ready), 32'h0);
		check_value("dbg ready", 32'(dbg_rsp.ready), 32'h0);
		check_value("o_all_done", 32'(all_done), 32'h0);
		check_value("o_exit_req", 32'(exit_req), 32'h0);

		idx = 0;
		while (idx < table_q.size())
		begin
			if (table_q[idx].pair)
			begin
				fork
					run_entry(idx);
					run_entry(idx + 1);
				join
				idx += 2;
			end
			else
			begin
				run_entry(idx);
				idx++;
			end
		end
		$display("** PASS **");
		$finish;
	end

	// Budget of 20 cycles per entry plus margin for reset
	initial
	begin
		wait (table_ready);
		repeat (table_q.size() * 20 + 50) @(posedge rvx_port_08);
		$display("Watchdog expired before the stimulus table finished");
		$display("** FAIL **");
		$fatal(1);
	end

endmodule

// File: flist.f
design/plat_pkg.sv
design/plat_sync_bank.sv
design/plat_bus_arbiter.sv
design/plat_vector_table.sv
design/plat_finish_counter.sv
design/plat_ctrl.sv
design/plat_top.sv
sim/plat_sva.sv
sim/plat_tb.sv

// File: Makefile
# Verilator build for the platform controller testbench

VERILATOR ?= verilator
TOP       ?= plat_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM       ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulator is the test result
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
